// File: src.f
neuronPkg.sv
weightBus.sv
floatMul.sv
floatAdd.sv
weightRegs.sv
neuronNode.sv
neuronTop.sv
tbNeuron.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbNeuron -f src.f -o simNeuron
out=$(./obj_dir/simNeuron)
echo "$out"
if echo "$out" | grep -q "Everything OK"
then
	exit 0
fi
exit 1

// File: tbNeuron.sv
`timescale 1ns/1ps
`default_nettype none

module tbNeuron;
	import neuronPkg::*;

	localparam logic [31:0] REF_W [0:9] = '{
		32'h3f00_0000, 32'hbe80_0000, 32'h3fc0_0000, 32'hbf80_0000, 32'h3f40_0000,
		32'h4000_0000, 32'hbf00_0000, 32'h3e00_0000, 32'hbfa0_0000, 32'h3e99_999a};
	localparam logic [31:0] REF_B = 32'h3dcc_cccd;

	logic clk = 1'b0;
	logic rst;
	logic cfgWe;
	logic [CFG_AW-1:0] cfgAddr;
	floatT cfgData;
	logic inStrobe;
	actVecT inData;
	logic outStrobe;
	floatT outData;
	logic ready;

	floatT wModel [0:9];
	floatT bModel;
	floatT expQ [$]; // Expected outputs in strobe order.
	int cycQ [$];
	int cyc = 0;
	int errors = 0;
	int errMark = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	floatT expVal;
	int sentAt;
	actVecT vec;

	neuronTop #(.Lanes(LANES)) dut
	(
		.clk(clk),
		.rst(rst),
		.cfgWe(cfgWe),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.inStrobe(inStrobe),
		.inData(inData),
		.outStrobe(outStrobe),
		.outData(outData),
		.ready(ready)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic floatT refMul(input floatT a, input floatT b);
		logic [47:0] prod;
		int ex;
		if (a.expo == 8'd0 || b.expo == 8'd0)
			return FLOAT_ZERO;
		prod = {24'd0, 1'b1, a.frac} * {24'd0, 1'b1, b.frac};
		ex = int'(a.expo) + int'(b.expo) - 127;
		if (prod[47])
		begin
			prod = prod >> 1;
			ex = ex + 1;
		end
		if (ex < 1)
			return FLOAT_ZERO;
		if (ex > 254)
			return (a.sign ^ b.sign) ? FLOAT_MAX_NEG : FLOAT_MAX_POS;
		return {a.sign ^ b.sign, ex[7:0], prod[45:23]};
	endfunction

	function automatic floatT refAdd(input floatT a, input floatT b);
		floatT x;
		floatT y;
		logic [25:0] m;
		int ex;
		if (a.expo == 8'd0)
			return b;
		if (b.expo == 8'd0)
			return a;
		x = (a[30:0] >= b[30:0]) ? a : b; // The larger magnitude sets sign and exponent.
		y = (a[30:0] >= b[30:0]) ? b : a;
		m = {3'b001, y.frac} >> (x.expo - y.expo);
		m = (x.sign == y.sign) ? {3'b001, x.frac} + m : {3'b001, x.frac} - m;
		ex = int'(x.expo);
		if (m == 26'd0)
			return FLOAT_ZERO;
		if (m[24])
		begin
			m = m >> 1;
			ex = ex + 1;
		end
		while (!m[23])
		begin
			m = m << 1;
			ex = ex - 1;
		end
		if (ex < 1)
			return FLOAT_ZERO;
		if (ex > 254)
			return x.sign ? FLOAT_MAX_NEG : FLOAT_MAX_POS;
		return {x.sign, ex[7:0], m[22:0]};
	endfunction

	function automatic floatT refNeuron(input actVecT x);
		floatT m [0:9];
		floatT q0, q1, q2, sum;
		for (int i = 0; i < 10; i++)
			m[i] = refMul(x[i], wModel[i]);
		q0 = refAdd(refAdd(m[0], m[1]), refAdd(m[2], m[3]));
		q1 = refAdd(refAdd(m[4], m[5]), refAdd(m[6], m[7]));
		q2 = refAdd(refAdd(m[8], m[9]), bModel);
		sum = refAdd(refAdd(q0, q1), q2);
		return sum.sign ? FLOAT_ZERO : sum;
	endfunction

	function automatic floatT randFloat(); // Magnitude between 0.25 and 4.
		return {1'($urandom), 8'(125 + $urandom % 4), 23'($urandom)};
	endfunction

	function automatic actVecT randVec();
		actVecT x;
		for (int i = 0; i < LANES; i++)
			x[i] = randFloat();
		return x;
	endfunction

	task automatic checkFloat(input string name, input floatT gotV, input floatT wantV);
		if (gotV !== wantV)
		begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, gotV, wantV);
			errors++;
		end
	endtask

	task automatic checkBit(input string name, input logic gotV, input logic wantV);
		if (gotV !== wantV)
		begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, gotV, wantV);
			errors++;
		end
	endtask

	task automatic writeCfg(input logic [CFG_AW-1:0] addr, input floatT data);
		@(negedge clk);
		inStrobe = 1'b0;
		cfgWe = 1'b1;
		cfgAddr = addr;
		cfgData = data;
		if (addr < BIAS_ADDR)
			wModel[addr] = data;
		else if (addr == BIAS_ADDR)
			bModel = data;
	endtask

	task automatic sendVec(input actVecT x);
		@(negedge clk);
		cfgWe = 1'b0;
		inStrobe = 1'b1;
		inData = x;
		expQ.push_back(refNeuron(x)); // Weights as they stand at this strobe.
		cycQ.push_back(cyc);
	endtask

	task automatic waitReady();
		for (int i = 0; i < 50 && !ready; i++)
		begin
			@(negedge clk);
			cfgWe = 1'b0;
		end
		if (!ready)
		begin
			$display("Timeout: ready never went high after loading.");
			errors++;
		end
	endtask

	task automatic waitDrain();
		for (int i = 0; i < 50 && expQ.size() > 0; i++)
		begin
			@(negedge clk);
			inStrobe = 1'b0;
			cfgWe = 1'b0;
		end
		if (expQ.size() > 0)
		begin
			$display("Timeout: %0d outputs never arrived.", expQ.size());
			errors++;
			expQ.delete();
			cycQ.delete();
		end
	endtask

	task automatic endTest(input string name);
		if (errors == errMark)
			testsPassed++;
		else
			testsFailed++;
		$display("Test %s: %0d errors", name, errors - errMark);
		errMark = errors;
	endtask

	always @(negedge clk)
	begin
		if (!rst && outStrobe)
		begin
			if (expQ.size() == 0)
			begin
				$display("Output strobe at %0t without a vector in flight.", $time);
				errors++;
			end
			else
			begin
				expVal = expQ.pop_front();
				sentAt = cycQ.pop_front();
				checkFloat("outData", outData, expVal);
				if (cyc - sentAt != 3)
				begin
					$display("Output at %0t came %0d cycles after its strobe.", $time, cyc - sentAt);
					errors++;
				end
			end
		end
	end

	initial
	begin
		void'($urandom(32'hbaf));
		rst = 1'b1;
		cfgWe = 1'b0;
		cfgAddr = '0;
		cfgData = FLOAT_ZERO;
		inStrobe = 1'b0;
		inData = '0;
		bModel = FLOAT_ZERO;
		for (int i = 0; i < LANES; i++)
			wModel[i] = FLOAT_ZERO;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		checkBit("outStrobe", outStrobe, 1'b0);
		checkBit("ready", ready, 1'b0);
		for (int i = 0; i < LANES; i++)
			writeCfg(4'(i), REF_W[i]);
		writeCfg(4'd12, 32'h4000_0000);
		writeCfg(BIAS_ADDR, REF_B);
		checkBit("ready", ready, 1'b0); // Still reflects the writes before the bias.
		waitReady();
		endTest("reset and load");

		for (int n = 0; n < 8; n++)
			sendVec(randVec());
		waitDrain();
		endTest("reference weights");

		for (int i = 0; i < LANES; i++)
			vec[i] = {~wModel[i].sign, 8'd127, 23'd0};
		sendVec(vec);
		vec = '0;
		vec[5] = 32'h3f80_0000;
		sendVec(vec);
		waitDrain();
		endTest("ReLU");

		writeCfg(4'd0, 32'h7f00_0000); // A huge weight so a zero-exponent lane must really count as zero.
		for (int i = 0; i < LANES; i++)
			vec[i] = {1'b0, 8'd0, 23'($urandom)};
		sendVec(vec);
		for (int i = 0; i < LANES; i++)
			vec[i] = {1'b0, 8'd1, 23'($urandom)};
		sendVec(vec);
		for (int i = 0; i < LANES; i++)
			vec[i] = {wModel[i].sign, 8'd254, 23'($urandom)};
		sendVec(vec);
		writeCfg(4'd0, REF_W[0]);
		vec = '0;
		vec[0] = 32'h3f80_0000; // 1.0 times 0.5 cancels 2.0 times -0.25.
		vec[1] = 32'h4000_0000;
		sendVec(vec);
		waitDrain();
		endTest("float corners");

		for (int i = 0; i < LANES; i++)
			writeCfg(4'(i), randFloat());
		writeCfg(BIAS_ADDR, randFloat());
		for (int n = 0; n < 20; n++)
			sendVec(randVec());
		waitDrain();
		endTest("back-to-back");

		vec = randVec();
		sendVec(vec);
		writeCfg(4'd3, randFloat());
		sendVec(vec);
		waitDrain();
		endTest("weight update timing");

		$display("Tests passed: %0d, failed: %0d, errors: %0d", testsPassed, testsFailed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: neuronTop.sv
`timescale 1ns/1ps
`default_nettype none

module neuronTop #(
	parameter int Lanes = neuronPkg::LANES
)
(
	input  logic clk,
	input  logic rst,
	input  logic cfgWe,
	input  logic [neuronPkg::CFG_AW-1:0] cfgAddr,
	input  neuronPkg::floatT cfgData,
	input  logic inStrobe,
	input  neuronPkg::actVecT inData,
	output logic outStrobe,
	output neuronPkg::floatT outData,
	output logic ready
);

	weightBus #(.Lanes(Lanes)) bus ();

	weightRegs #(.Lanes(Lanes)) uRegs
	(
		.clk(clk),
		.rst(rst),
		.cfgWe(cfgWe),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.bus(bus)
	);

	neuronNode #(.Lanes(Lanes)) uNode
	(
		.clk(clk),
		.rst(rst),
		.inStrobe(inStrobe),
		.inData(inData),
		.bus(bus),
		.outStrobe(outStrobe),
		.outData(outData)
	);

	assign ready = bus.loaded;

endmodule

`default_nettype wire

// File: neuronNode.sv
`timescale 1ns/1ps
`default_nettype none

module neuronNode #(
	parameter int Lanes = neuronPkg::LANES
)
(
	input  logic clk,
	input  logic rst,
	input  logic inStrobe,
	input  neuronPkg::actVecT inData,
	weightBus.user bus,
	output logic outStrobe,
	output neuronPkg::floatT outData
);
	import neuronPkg::*;

	floatT [Lanes-1:0] prodW;
	floatT [Lanes-1:0] prodQ;
	floatT [Lanes/2-1:0] pairW;
	floatT [Lanes/2-1:0] pairQ;
	floatT biasQ1;
	floatT biasQ2;
	floatT q0, q1, q2, r, sum;
	floatT resultQ;
	logic [2:0] validQ;

	if (Lanes != 10)
	begin : gLanesCheck
		$error("The adder tree of neuronNode is built for ten lanes.");
	end

	for (genvar i = 0; i < Lanes; i++)
	begin : gMul
		floatMul uMul (.a(inData[i]), .b(bus.weights[i]), .p(prodW[i]));
	end

	for (genvar i = 0; i < Lanes / 2; i++)
	begin : gPair
		floatAdd uPair (.a(prodQ[2*i]), .b(prodQ[2*i+1]), .s(pairW[i]));
	end

	floatAdd uQ0 (.a(pairQ[0]), .b(pairQ[1]), .s(q0));
	floatAdd uQ1 (.a(pairQ[2]), .b(pairQ[3]), .s(q1));
	floatAdd uQ2 (.a(pairQ[4]), .b(biasQ2), .s(q2));
	floatAdd uR (.a(q0), .b(q1), .s(r));
	floatAdd uSum (.a(r), .b(q2), .s(sum));

	always_ff @(posedge clk)
	begin
		if (rst)
			validQ <= '0;
		else
			validQ <= {validQ[1:0], inStrobe};
	end

	// The bias travels with its vector so a later write cannot mix into it.
	always_ff @(posedge clk)
	begin
		prodQ <= prodW;
		biasQ1 <= bus.bias;
		pairQ <= pairW;
		biasQ2 <= biasQ1;
		resultQ <= sum.sign ? FLOAT_ZERO : sum; // ReLU.
	end

	assign outStrobe = validQ[2];
	assign outData = resultQ;

	aReluSign: assert property (@(posedge clk) disable iff (rst) outStrobe |-> !outData.sign)
		else $error("Negative value left the ReLU.");

	aLatency: assert property (@(posedge clk) disable iff (rst)
		!($past(rst, 1) || $past(rst, 2) || $past(rst, 3)) |-> outStrobe == $past(inStrobe, 3))
		else $error("Output strobe does not follow the input strobe by three cycles.");

endmodule

`default_nettype wire

// File: weightRegs.sv
`timescale 1ns/1ps
`default_nettype none

module weightRegs #(
	parameter int Lanes = neuronPkg::LANES
)
(
	input logic clk,
	input logic rst,
	input logic cfgWe,
	input logic [neuronPkg::CFG_AW-1:0] cfgAddr,
	input neuronPkg::floatT cfgData,
	weightBus.cfg bus
);
	import neuronPkg::*;

	floatT [Lanes-1:0] weightQ;
	floatT biasQ;
	logic [Lanes:0] writtenQ; // Top bit tracks the bias.

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < Lanes; i++)
				weightQ[i] <= FLOAT_ZERO;
			biasQ <= FLOAT_ZERO;
			writtenQ <= '0;
		end
		else if (cfgWe)
		begin
			for (int i = 0; i < Lanes; i++)
			begin
				if (cfgAddr == CFG_AW'(i))
				begin
					weightQ[i] <= cfgData;
					writtenQ[i] <= 1'b1;
				end
			end
			if (cfgAddr == BIAS_ADDR)
			begin
				biasQ <= cfgData;
				writtenQ[Lanes] <= 1'b1;
			end
		end
	end

	assign bus.weights = weightQ;
	assign bus.bias = biasQ;
	assign bus.loaded = &writtenQ;

	aWeAddrKnown: assert property (@(posedge clk) disable iff (rst) cfgWe |-> !$isunknown(cfgAddr))
		else $error("Configuration write with unknown address.");

endmodule

`default_nettype wire

// File: floatAdd.sv
`timescale 1ns/1ps
`default_nettype none

module floatAdd
(
	input  neuronPkg::floatT a,
	input  neuronPkg::floatT b,
	output neuronPkg::floatT s
);
	import neuronPkg::*;

	neuronPkg::floatT bigOp;
	neuronPkg::floatT litOp;
	logic [7:0] expDiff;
	logic [24:0] sigBig;
	logic [24:0] sigLit;
	logic [24:0] sigSum;
	logic [23:0] sigNorm;
	logic [4:0] lead;
	logic signed [9:0] expRes;

	// Order the operands by magnitude and align the smaller one.
	always_comb
	begin
		if (a[30:0] >= b[30:0])
		begin
			bigOp = a;
			litOp = b;
		end
		else
		begin
			bigOp = b;
			litOp = a;
		end

		expDiff = bigOp.expo - litOp.expo;
		sigBig = {2'b01, bigOp.frac};
		sigLit = {2'b01, litOp.frac} >> expDiff; // Shifted-out bits are dropped.

		if (bigOp.sign == litOp.sign)
			sigSum = sigBig + sigLit;
		else
			sigSum = sigBig - sigLit;
	end

	// Normalize by one bit right on carry, otherwise left by the leading-zero count.
	always_comb
	begin
		lead = '0;
		for (int i = 0; i < 24; i++)
		begin
			if (sigSum[i])
				lead = 5'(23 - i);
		end

		if (sigSum[24])
		begin
			sigNorm = sigSum[24:1];
			expRes = $signed({2'b00, bigOp.expo}) + 10'sd1;
		end
		else
		begin
			sigNorm = sigSum[23:0] << lead;
			expRes = $signed({2'b00, bigOp.expo}) - $signed({5'b00000, lead});
		end
	end

	always_comb
	begin
		if (a.expo == 8'd0)
		begin
			s = b;
		end
		else if (b.expo == 8'd0)
		begin
			s = a;
		end
		else if (sigSum == 25'd0 || expRes < EXP_MIN)
		begin
			s = FLOAT_ZERO; // Cancellation and underflow both give plus zero.
		end
		else if (expRes > EXP_MAX)
		begin
			s = bigOp.sign ? FLOAT_MAX_NEG : FLOAT_MAX_POS;
		end
		else
		begin
			s = {bigOp.sign, expRes[7:0], sigNorm[22:0]};
		end
	end

endmodule

`default_nettype wire

// File: floatMul.sv
`timescale 1ns/1ps
`default_nettype none

module floatMul
(
	input  neuronPkg::floatT a,
	input  neuronPkg::floatT b,
	output neuronPkg::floatT p
);
	import neuronPkg::*;

	logic sign;
	logic [47:0] prod;
	logic signed [9:0] expSum;
	logic [22:0] frac;

	always_comb
	begin
		sign = a.sign ^ b.sign;
		prod = 48'({1'b1, a.frac}) * 48'({1'b1, b.frac});
		expSum = $signed({2'b00, a.expo}) + $signed({2'b00, b.expo}) - EXP_BIAS;

		// The product of two significands lies in [1, 4).
		if (prod[47])
		begin
			frac = prod[46:24];
			expSum = expSum + 10'sd1;
		end
		else
		begin
			frac = prod[45:23];
		end

		if (a.expo == 8'd0 || b.expo == 8'd0)
		begin
			p = FLOAT_ZERO;
		end
		else if (expSum < EXP_MIN)
		begin
			p = FLOAT_ZERO; // Underflow flushes to plus zero.
		end
		else if (expSum > EXP_MAX)
		begin
			p = sign ? FLOAT_MAX_NEG : FLOAT_MAX_POS;
		end
		else
		begin
			p = {sign, expSum[7:0], frac};
		end
	end

endmodule

`default_nettype wire

// File: weightBus.sv
`timescale 1ns/1ps
`default_nettype none

interface weightBus #(
	parameter int Lanes = neuronPkg::LANES
) ();
	import neuronPkg::*;

	floatT [Lanes-1:0] weights;
	floatT bias;
	logic loaded; // High once every weight and the bias have been written.

	modport cfg (output weights, output bias, output loaded);
	modport user (input weights, input bias, input loaded);

endinterface

`default_nettype wire

// File: neuronPkg.sv
`default_nettype none

package neuronPkg;

	// IEEE single-precision layout.
	typedef struct packed
	{
		logic        sign;
		logic [7:0]  expo;
		logic [22:0] frac;
	} floatT;

	// Activations per neuron.
	localparam int LANES = 10;

	typedef floatT [LANES-1:0] actVecT;

	// Addresses 0 to LANES-1 hold the weights and BIAS_ADDR holds the bias.
	localparam int CFG_AW = 4;
	localparam logic [CFG_AW-1:0] BIAS_ADDR = 4'd10;

	// Exponent arithmetic runs on 10-bit signed values so that underflow shows as a negative.
	localparam logic signed [9:0] EXP_BIAS = 10'sd127;
	localparam logic signed [9:0] EXP_MIN = 10'sd1;
	localparam logic signed [9:0] EXP_MAX = 10'sd254;

	localparam floatT FLOAT_MAX_POS = 32'h7f7f_ffff; // Largest finite positive value.
	localparam floatT FLOAT_MAX_NEG = 32'hff7f_ffff;
	localparam floatT FLOAT_ZERO = 32'h0000_0000;

endpackage

`default_nettype wire
